/* alu.sv */
// Start is only honoured while idle and the multiply clears the carry flag
`timescale 1ns/1ps

module alu #(
  parameter int NIBBLE_WIDTH = 4
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  exec_pkg::alu_req_t req,
  output exec_pkg::alu_rsp_t rsp
);
  import exec_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_addsub,
    st_mul
  } state_e;

  state_e                state;
  logic [data_width-1:0] result_q;
  logic                  zero_q;
  logic                  carry_q;
  logic                  is_sub;
  logic [data_width-1:0] b_eff;
  logic [data_width:0]   sum;
  logic                  mul_start;
  logic                  mul_done;
  logic [data_width-1:0] product;

  // Subtract is add with the second operand inverted and carry in set
  // Carry out then reads as no borrow
  assign is_sub = (req.op == op_sub);
  assign b_eff  = is_sub ? ~req.b : req.b;
  assign sum    = {1'b0, req.a} + {1'b0, b_eff} + {{data_width{1'b0}}, is_sub};

  // The multiplier only sees a start when the FSM is free to wait for it
  assign mul_start = start & (state == st_idle) & (req.op == op_mul);

  nibble_multiplier #(
    .NIBBLE_WIDTH(NIBBLE_WIDTH)
  ) u_mul (
    .clk         (clk),
    .reset       (reset),
    .mul_start   (mul_start),
    .multiplicand(req.a),
    .multiplier  (req.b),
    .product     (product),
    .mul_done    (mul_done)
  );

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= st_idle;
      // A cleared result reads back with the zero flag set
      result_q <= '0;
      zero_q   <= 1'b1;
      carry_q  <= 1'b0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (start)
          begin
            case (req.op)
              op_add, op_sub:
              begin
                result_q <= sum[data_width-1:0];
                zero_q   <= (sum[data_width-1:0] == '0);
                carry_q  <= sum[data_width];
                state    <= st_addsub;
              end
              op_mul:
                state <= st_mul;
              // Reserved code starts nothing and keeps result and flags
              default:
                state <= st_idle;
            endcase
          end
        end
        // Add and subtract are already registered, hold busy for one cycle
        st_addsub:
          state <= st_idle;
        st_mul:
        begin
          if (mul_done)
          begin
            result_q <= product;
            zero_q   <= (product == '0);
            carry_q  <= 1'b0;
            state    <= st_idle;
          end
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  assign rsp = '{result: result_q, zero: zero_q, carry: carry_q, busy: (state != st_idle)};

endmodule

/* alu_regs.sv */
// Every write is a full word since sel is ignored and a control write while busy is dropped
`timescale 1ns/1ps

module alu_regs (
  input  logic               clk,
  input  logic               reset,
  input  exec_pkg::wb_req_t  wb_req,
  input  exec_pkg::alu_rsp_t alu_rsp,
  output exec_pkg::wb_rsp_t  wb_rsp,
  output exec_pkg::alu_req_t alu_req,
  output logic               start
);
  import exec_pkg::*;

  logic                  ack_q;
  logic [data_width-1:0] operand_a;
  logic [data_width-1:0] operand_b;
  alu_op_e               last_op;
  reg_idx_e              idx;
  alu_op_e               write_op;
  logic                  write_cycle;
  logic                  control_write;
  logic [data_width-1:0] status_word;
  logic [data_width-1:0] read_data;

  // Byte address selects one of four words
  assign idx      = reg_idx_e'(wb_req.adr[3:2]);
  assign write_op = alu_op_e'(wb_req.dat_w[1:0]);

  // Writes take effect in the ack cycle while the master still holds the request
  assign write_cycle   = ack_q & wb_req.cyc & wb_req.stb & wb_req.we;
  assign control_write = write_cycle & (idx == reg_control);

  // A busy ALU swallows the control write without starting anything
  assign start = control_write & ~alu_rsp.busy;

  // Ack follows one cycle after the strobe is seen and lasts exactly one cycle
  always_ff @(posedge clk)
  begin
    if (reset)
      ack_q <= 1'b0;
    else
      ack_q <= wb_req.cyc & wb_req.stb & ~ack_q;
  end

  // Operand and op code registers
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      operand_a <= '0;
      operand_b <= '0;
      last_op   <= op_add;
    end
    else
    begin
      if (write_cycle && (idx == reg_operand_a))
        operand_a <= wb_req.dat_w;
      if (write_cycle && (idx == reg_operand_b))
        operand_b <= wb_req.dat_w;
      // Only an accepted control write updates the op field
      if (start)
        last_op <= write_op;
    end
  end

  // Status word collects the ALU flags and the last accepted op code
  always_comb
  begin
    status_word                   = '0;
    status_word[status_busy_bit]  = alu_rsp.busy;
    status_word[status_zero_bit]  = alu_rsp.zero;
    status_word[status_carry_bit] = alu_rsp.carry;
    status_word[1:0]              = last_op;
  end

  // Read data is valid while ack is high, the result register is read only
  always_comb
  begin
    case (idx)
      reg_operand_a:
        read_data = operand_a;
      reg_operand_b:
        read_data = operand_b;
      reg_control:
        read_data = status_word;
      default:
        read_data = alu_rsp.result;
    endcase
  end

  // The op travels with the start pulse straight from the bus data
  assign alu_req = '{op: write_op, a: operand_a, b: operand_b};
  assign wb_rsp  = '{ack: ack_q, dat_r: read_data};

endmodule

/* exec_pkg.sv */
// The datapath is fixed at 32 bits by the Wishbone port and byte selects are carried but never used
package exec_pkg;

  // Width of operands, results and the bus data path
  localparam int data_width = 32;

  // Operation codes as written to the control register
  typedef enum logic [1:0] {
    op_add  = 2'd0,
    op_sub  = 2'd1,
    op_mul  = 2'd2,
    op_rsvd = 2'd3
  } alu_op_e;

  // Word index taken from address bits 3:2
  typedef enum logic [1:0] {
    reg_operand_a = 2'd0,
    reg_operand_b = 2'd1,
    reg_control   = 2'd2,
    reg_result    = 2'd3
  } reg_idx_e;

  // Bit positions of the flags in the status word, the op code sits in bits 1:0
  localparam int status_busy_bit  = 31;
  localparam int status_zero_bit  = 30;
  localparam int status_carry_bit = 29;

  // Wishbone classic request from the host
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [3:0]            adr;
    logic [data_width-1:0] dat_w;
    logic [3:0]            sel;
  } wb_req_t;

  // Wishbone classic response to the host
  typedef struct packed {
    logic                  ack;
    logic [data_width-1:0] dat_r;
  } wb_rsp_t;

  // Operation and operands handed to the ALU with the start pulse
  typedef struct packed {
    alu_op_e               op;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
  } alu_req_t;

  // Registered result, flags and busy state returned by the ALU
  typedef struct packed {
    logic [data_width-1:0] result;
    logic                  zero;
    logic                  carry;
    logic                  busy;
  } alu_rsp_t;

endpackage

/* exec_unit_top.sv */
// NIBBLE_WIDTH must be 1, 2, 4 or 8 and sets the multiply latency to 32/NIBBLE_WIDTH cycles
`timescale 1ns/1ps

module exec_unit_top #(
  parameter int NIBBLE_WIDTH = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  exec_pkg::wb_req_t wb_req,
  output exec_pkg::wb_rsp_t wb_rsp
);
  import exec_pkg::*;

  // Request and start from the register block, status back from the ALU
  alu_req_t alu_req;
  alu_rsp_t alu_rsp;
  logic     start;

  // Bus slave holding operands and control
  alu_regs u_regs (
    .clk    (clk),
    .reset  (reset),
    .wb_req (wb_req),
    .alu_rsp(alu_rsp),
    .wb_rsp (wb_rsp),
    .alu_req(alu_req),
    .start  (start)
  );

  // Execution datapath with the serial multiplier inside
  alu #(
    .NIBBLE_WIDTH(NIBBLE_WIDTH)
  ) u_alu (
    .clk  (clk),
    .reset(reset),
    .start(start),
    .req  (alu_req),
    .rsp  (alu_rsp)
  );

endmodule

/* nibble_multiplier.sv */
// Keeps only the low 32 bits of an unsigned product and NIBBLE_WIDTH must divide 32 evenly
`timescale 1ns/1ps

module nibble_multiplier #(
  parameter int NIBBLE_WIDTH = 4
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            mul_start,
  input  logic [exec_pkg::data_width-1:0] multiplicand,
  input  logic [exec_pkg::data_width-1:0] multiplier,
  output logic [exec_pkg::data_width-1:0] product,
  output logic                            mul_done
);
  import exec_pkg::*;

  // One step per nibble of the multiplier
  localparam int steps       = data_width / NIBBLE_WIDTH;
  localparam int count_width = (steps > 1) ? $clog2(steps) : 1;

  logic                   running;
  logic [count_width-1:0] step_count;
  logic                   last_step;
  logic [data_width-1:0]  mcand_q;
  logic [data_width-1:0]  mplier_q;
  logic [data_width-1:0]  acc_q;
  logic [data_width-1:0]  partial;
  logic [data_width-1:0]  acc_next;

  // Multiplicand times the lowest remaining nibble, truncated to the low word
  assign partial  = mcand_q * data_width'(mplier_q[NIBBLE_WIDTH-1:0]);
  assign acc_next = acc_q + partial;

  assign last_step = (step_count == count_width'(steps - 1));

  // Step counter and run flag
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      running    <= 1'b0;
      step_count <= '0;
    end
    else if (mul_start)
    begin
      running    <= 1'b1;
      step_count <= '0;
    end
    else if (running)
    begin
      step_count <= step_count + 1'b1;
      // The run ends once the last nibble has been folded in
      if (last_step)
        running <= 1'b0;
    end
  end

  // Shift-and-add datapath
  always_ff @(posedge clk)
  begin
    if (mul_start)
    begin
      mcand_q  <= multiplicand;
      mplier_q <= multiplier;
      acc_q    <= '0;
    end
    else if (running)
    begin
      acc_q    <= acc_next;
      // Next nibble of the multiplier weighs NIBBLE_WIDTH bits more
      mcand_q  <= mcand_q << NIBBLE_WIDTH;
      mplier_q <= mplier_q >> NIBBLE_WIDTH;
    end
  end

  // In the last step the sum including the final partial product is already complete
  // So the caller can capture it on the same edge the run ends
  assign product  = acc_next;
  assign mul_done = running & last_step;

endmodule

/* sim.f */
+incdir+.
exec_pkg.sv
nibble_multiplier.sv
alu.sv
alu_regs.sv
exec_unit_top.sv
tb_exec_unit.sv

/* tb_exec_unit_pkg.svh */
// Included inside tb_exec_unit after clk, wb_req, wb_rsp and the test counters are declared
`ifndef tb_exec_unit_pkg_svh
`define tb_exec_unit_pkg_svh

// One table row with the stimulus and the values the DUT must return
typedef struct packed {
  alu_op_e               op;
  logic [data_width-1:0] a;
  logic [data_width-1:0] b;
  logic [data_width-1:0] result;
  logic                  zero;
  logic                  carry;
} row_t;

// Compares an expected value with what the DUT returned
task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
  if (expected !== actual)
  begin
    $display("Error at %0d ns: %s expected 0x%08h, got 0x%08h", $time, name, expected, actual);
    error_count++;
  end
endtask

// One Wishbone classic cycle, started and ended on a falling edge
task automatic wb_transfer(input logic we, input reg_idx_e idx, input logic [31:0] dat_w,
                           output logic [31:0] dat_r);
  int waited;
  waited = 0;
  wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: {idx, 2'b00}, dat_w: dat_w, sel: 4'hf};
  @(negedge clk);
  while (!wb_rsp.ack && waited < 16)
  begin
    @(negedge clk);
    waited++;
  end
  if (!wb_rsp.ack)
  begin
    $display("The DUT never acknowledged the access to register %0d", idx);
    error_count++;
  end
  dat_r = wb_rsp.dat_r;
  // The slave commits a write at the end of the ack cycle, so hold the request until then
  @(negedge clk);
  wb_req = '0;
endtask

task automatic wb_write(input reg_idx_e idx, input logic [31:0] data);
  logic [31:0] unused;
  wb_transfer(1'b1, idx, data, unused);
endtask

task automatic wb_read(input reg_idx_e idx, output logic [31:0] data);
  wb_transfer(1'b0, idx, '0, data);
endtask

// Reads the status until busy clears and returns the last status word
task automatic poll_idle(output logic [31:0] status);
  int polls;
  polls = 0;
  wb_read(reg_control, status);
  while (status[status_busy_bit] && polls < 32)
  begin
    wb_read(reg_control, status);
    polls++;
  end
  if (status[status_busy_bit])
  begin
    $display("The DUT stayed busy after %0d status reads", polls);
    error_count++;
  end
endtask

// Prints one line for a finished test and counts it
task automatic finish_test(input string name, input int errors_before);
  if (error_count == errors_before)
  begin
    $display("%s: passed", name);
    pass_count++;
  end
  else
  begin
    $display("%s: failed", name);
    fail_count++;
  end
endtask

// Expected result and flags from the operation rules, multiply leaves carry clear
function automatic row_t model_alu(input row_t row);
  row_t            r;
  logic [data_width:0] wide;
  r = row;
  case (row.op)
    op_add:
    begin
      wide     = {1'b0, row.a} + {1'b0, row.b};
      r.result = wide[data_width-1:0];
      r.carry  = wide[data_width];
    end
    // Carry reads as no borrow
    op_sub:
    begin
      r.result = row.a - row.b;
      r.carry  = (row.a >= row.b);
    end
    default:
    begin
      r.result = row.a * row.b;
      r.carry  = 1'b0;
    end
  endcase
  r.zero = (r.result == '0);
  return r;
endfunction

`endif

/* tb_exec_unit.sv */
// Runs the DUT with NIBBLE_WIDTH 4 and only polls busy, so it does not pin exact latencies
`timescale 1ns/1ps

module tb_exec_unit;
  import exec_pkg::*;

  localparam int clk_period  = 4;
  localparam int hand_rows   = 6;
  localparam int row_count   = hand_rows + 16;
  // Reset, read back, reserved op and overlap tests are budgeted like table rows
  localparam int extra_tests = 5;
  localparam int time_limit  = (row_count + extra_tests) * (8 + 12) * clk_period * 2;

  logic    clk;
  logic    reset;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  int      error_count;
  int      pass_count;
  int      fail_count;
  integer  seed;

  `include "tb_exec_unit_pkg.svh"

  row_t table_rows [row_count];

  exec_unit_top #(
    .NIBBLE_WIDTH(4)
  ) u_dut (
    .clk   (clk),
    .reset (reset),
    .wb_req(wb_req),
    .wb_rsp(wb_rsp)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Watchdog
  initial
  begin
    #(time_limit);
    $display("Timeout: the tests did not finish within %0d ns", time_limit);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin : stimulus
    logic [31:0] data;
    logic [31:0] status;
    row_t        row;
    int          errors_before;
    reset       = 1'b1;
    wb_req      = '0;
    error_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    seed        = 32'he5a2_81ab;
    // Hand rows cover carry out, equal subtract, borrow and multiply corner cases
    table_rows[0] = '{op_add, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 1'b1, 1'b1};
    table_rows[1] = '{op_sub, 32'h1234_5678, 32'h1234_5678, 32'h0000_0000, 1'b1, 1'b1};
    table_rows[2] = '{op_sub, 32'h0000_0005, 32'h0000_0007, 32'hffff_fffe, 1'b0, 1'b0};
    table_rows[3] = '{op_mul, 32'hdead_beef, 32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0};
    table_rows[4] = '{op_mul, 32'h0001_0000, 32'h0001_0000, 32'h0000_0000, 1'b1, 1'b0};
    table_rows[5] = '{op_mul, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001, 1'b0, 1'b0};
    for (int i = hand_rows; i < row_count; i++)
    begin
      row       = '0;
      row.op    = alu_op_e'($unsigned($random(seed)) % 3);
      row.a     = $random(seed);
      row.b     = $random(seed);
      table_rows[i] = model_alu(row);
    end
    repeat (8) @(negedge clk);
    reset = 1'b0;

    // Everything clears on reset, a zero result shows up as the zero flag
    errors_before = error_count;
    for (int i = 0; i < 4; i++)
    begin
      wb_read(reg_idx_e'(i), data);
      check($sformatf("register %0d", i), (i == 2) ? 32'h4000_0000 : 32'h0, data);
    end
    finish_test("reset values", errors_before);

    errors_before = error_count;
    wb_write(reg_operand_a, 32'h1234_5678);
    wb_write(reg_operand_b, 32'h9abc_def0);
    wb_write(reg_result, 32'hffff_ffff);
    wb_read(reg_operand_a, data);
    check("operand_a", 32'h1234_5678, data);
    wb_read(reg_operand_b, data);
    check("operand_b", 32'h9abc_def0, data);
    wb_read(reg_result, data);
    check("result", 32'h0, data);
    finish_test("register read back", errors_before);

    for (int i = 0; i < row_count; i++)
    begin
      errors_before = error_count;
      row = table_rows[i];
      wb_write(reg_operand_a, row.a);
      wb_write(reg_operand_b, row.b);
      wb_write(reg_control, 32'(row.op));
      poll_idle(status);
      wb_read(reg_result, data);
      check("result", row.result, data);
      check("zero flag", row.zero, status[status_zero_bit]);
      check("carry flag", row.carry, status[status_carry_bit]);
      check("op field", row.op, status[1:0]);
      finish_test($sformatf("row %0d op %0d", i, row.op), errors_before);
    end

    // Reserved op is accepted but must leave the previous result and flags alone
    errors_before = error_count;
    // Fresh operands make any add, subtract or multiply by the reserved code show up
    wb_write(reg_operand_a, 32'h0000_0003);
    wb_write(reg_operand_b, 32'h0000_0005);
    wb_write(reg_control, 32'(op_rsvd));
    poll_idle(status);
    wb_read(reg_result, data);
    check("result", row.result, data);
    check("zero flag", row.zero, status[status_zero_bit]);
    check("carry flag", row.carry, status[status_carry_bit]);
    check("op field", op_rsvd, status[1:0]);
    finish_test("reserved op", errors_before);

    // An add written during a multiply must be dropped
    errors_before = error_count;
    wb_write(reg_operand_a, 32'h0000_1234);
    wb_write(reg_operand_b, 32'h0000_5678);
    wb_write(reg_control, 32'(op_mul));
    wb_read(reg_control, status);
    check("busy flag", 1'b1, status[status_busy_bit]);
    wb_write(reg_control, 32'(op_add));
    poll_idle(status);
    wb_read(reg_result, data);
    check("result", 32'h0626_0060, data);
    check("op field", op_mul, status[1:0]);
    finish_test("control write while busy", errors_before);

    $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && error_count == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
